//--- alu_unit.sv
// single-cycle add/logic unit; the result waits in its register for the bus
module alu_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  tomasulo_pkg::fu_req_t  req,
    input  logic                   grant,
    output tomasulo_pkg::cdb_t     result,
    output logic                   busy
);
    logic [tomasulo_pkg::XLEN-1:0] value;

    always_comb begin
        case (req.op)
            tomasulo_pkg::OP_ADD: value = req.a + req.b;
            tomasulo_pkg::OP_SUB: value = req.a - req.b;
            tomasulo_pkg::OP_AND: value = req.a & req.b;
            tomasulo_pkg::OP_OR:  value = req.a | req.b;
            tomasulo_pkg::OP_XOR: value = req.a ^ req.b;
            tomasulo_pkg::OP_SLT: value = {31'd0, $signed(req.a) < $signed(req.b)};
            default:              value = '0;
        endcase
    end

    // free again in the cycle the held result is granted
    assign busy = result.valid & ~grant;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result <= '0;
        end else if (req.valid) begin
            result <= '{valid: 1'b1, tag: req.tag, value: value};
        end else if (grant) begin
            result.valid <= 1'b0;
        end
    end

endmodule

//--- cdb_arbiter.sv
// picks one held unit result per cycle for the common data bus
// multiplier first since it has waited longest, then the alu
module cdb_arbiter (
    input  tomasulo_pkg::cdb_t alu_result,
    input  tomasulo_pkg::cdb_t mul_result,
    output tomasulo_pkg::cdb_t cdb,
    output logic               alu_grant,
    output logic               mul_grant
);

    always_comb begin
        mul_grant = mul_result.valid;
        alu_grant = alu_result.valid & ~mul_result.valid;
        if (mul_grant) begin
            cdb = mul_result;
        end else if (alu_grant) begin
            cdb = alu_result;
        end else begin
            cdb = '0;
        end
    end

endmodule

//--- commit_cases.txt
// first word: instruction count; then one line per instruction in program order
// columns (hex): instruction word, expected rd, expected write flag, expected value
0000001C
00500093 01 1 00000005
FFD08113 02 1 00000002
002081B3 03 1 00000007
40118233 04 1 00000002
003242B3 05 1 00000005
00112333 06 1 00000001
00C1F393 07 1 00000004
0043E433 08 1 00000006
021184B3 09 1 00000023
FFF00513 0A 1 FFFFFFFF
7FF00593 0B 1 000007FF
02B50633 0C 1 FFFFF801
001086B3 0D 1 0000000A
06400713 0E 1 00000064
02108733 0E 1 00000019
00170793 0F 1 0000001A
00708013 00 0 00000000
00100833 10 1 00000005
023108B3 11 1 0000000E
03188933 12 1 000000C4
02A509B3 13 1 00000001
02B60A33 14 1 FFC00FFF
000A2A93 15 1 00000001
0000AB03 00 0 00000000
00109BB3 00 0 00000000
010B0C33 18 1 00000005
0F054C93 19 1 FFFFFF0F
55506D13 1A 1 00000555

//--- flist.f
tomasulo_pkg.sv
alu_unit.sv
mul_unit.sv
cdb_arbiter.sv
reorder_buffer.sv
rs_bank.sv
issue_stage.sv
tomasulo_core.sv
tb_tomasulo_core.sv

//--- issue_stage.sv
// front end of the core: decodes one word per cycle, reads operands through
// the register status table and the reorder buffer, renames the destination
module issue_stage #(
    parameter int N_ALU_RS = 3,
    parameter int N_MUL_RS = 2
) (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             in_valid,
    input  tomasulo_pkg::instr_u             instr,
    input  logic [tomasulo_pkg::TAG_W-1:0]   alloc_tag,
    input  logic                             rob_full,
    input  tomasulo_pkg::rob_reply_t         reply,
    input  logic                             alu_full,
    input  logic                             mul_full,
    input  tomasulo_pkg::cdb_t               cdb,
    input  tomasulo_pkg::commit_t            commit,
    output logic                             stall,
    output tomasulo_pkg::rob_alloc_t         alloc,
    output logic                             alloc_valid,
    output tomasulo_pkg::rob_query_t         query,
    output tomasulo_pkg::rs_entry_t          rs_new,
    output logic                             rs_issue,
    output logic                             rs_is_mul
);
    localparam logic [6:0] OPC_REG = 7'b0110011;
    localparam logic [6:0] OPC_IMM = 7'b0010011;

    logic [tomasulo_pkg::XLEN-1:0]  regs [32];
    logic [31:0]                    stat_pend;
    logic [tomasulo_pkg::TAG_W-1:0] stat_tag [32];

    tomasulo_pkg::alu_op_e          op;
    logic                           use_imm;
    logic                           class_full;
    logic [4:0]                     rs1, rs2, rd;
    logic [tomasulo_pkg::XLEN-1:0]  imm_se;

    assign rs1    = instr.r_view.rs1;
    assign rs2    = instr.r_view.rs2;
    assign rd     = instr.r_view.rd;
    assign imm_se = {{20{instr.i_view.imm[11]}}, instr.i_view.imm};

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    always_comb begin
        op      = tomasulo_pkg::OP_NOP;
        use_imm = 1'b0;
        if (instr.r_view.opcode == OPC_REG) begin
            case ({instr.r_view.funct7, instr.r_view.funct3})
                {7'h00, 3'b000}: op = tomasulo_pkg::OP_ADD;
                {7'h20, 3'b000}: op = tomasulo_pkg::OP_SUB;
                {7'h01, 3'b000}: op = tomasulo_pkg::OP_MUL;
                {7'h00, 3'b111}: op = tomasulo_pkg::OP_AND;
                {7'h00, 3'b110}: op = tomasulo_pkg::OP_OR;
                {7'h00, 3'b100}: op = tomasulo_pkg::OP_XOR;
                {7'h00, 3'b010}: op = tomasulo_pkg::OP_SLT;
                default:         op = tomasulo_pkg::OP_NOP;
            endcase
        end else if (instr.i_view.opcode == OPC_IMM) begin
            use_imm = 1'b1;
            case (instr.i_view.funct3)
                3'b000:  op = tomasulo_pkg::OP_ADD;
                3'b111:  op = tomasulo_pkg::OP_AND;
                3'b110:  op = tomasulo_pkg::OP_OR;
                3'b100:  op = tomasulo_pkg::OP_XOR;
                3'b010:  op = tomasulo_pkg::OP_SLT;
                default: op = tomasulo_pkg::OP_NOP;
            endcase
        end
    end

    // a class built with no stations can never take an instruction
    assign rs_is_mul   = (op == tomasulo_pkg::OP_MUL);
    assign class_full  = rs_is_mul ? (N_MUL_RS == 0 || mul_full) : (N_ALU_RS == 0 || alu_full);
    assign stall       = rob_full | (in_valid & class_full);
    assign rs_issue    = in_valid & ~stall;
    assign alloc_valid = rs_issue;

    // unsupported words still take a slot and retire without a write
    assign alloc.rd    = (op != tomasulo_pkg::OP_NOP && rd != 5'd0) ? rd : 5'd0;
    assign alloc.write = (op != tomasulo_pkg::OP_NOP && rd != 5'd0);

    assign query.tag_j = stat_tag[rs1];
    assign query.tag_k = stat_tag[rs2];

    // operand read: register file, else finished rob entry, else bus this cycle
    always_comb begin
        rs_new     = '0;
        rs_new.op  = op;
        rs_new.tag = alloc_tag;
        if (op != tomasulo_pkg::OP_NOP) begin
            if (!stat_pend[rs1]) begin
                rs_new.vj = regs[rs1];
            end else if (reply.ready_j) begin
                rs_new.vj = reply.value_j;
            end else if (cdb.valid && cdb.tag == query.tag_j) begin
                rs_new.vj = cdb.value;
            end else begin
                rs_new.qj      = query.tag_j;
                rs_new.qj_pend = 1'b1;
            end
            if (use_imm) begin
                rs_new.vk = imm_se;
            end else if (!stat_pend[rs2]) begin
                rs_new.vk = regs[rs2];
            end else if (reply.ready_k) begin
                rs_new.vk = reply.value_k;
            end else if (cdb.valid && cdb.tag == query.tag_k) begin
                rs_new.vk = cdb.value;
            end else begin
                rs_new.qk      = query.tag_k;
                rs_new.qk_pend = 1'b1;
            end
        end
    end

    // --------------------------------------------------
    // register file and status table
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            stat_pend <= '0;
            for (int i = 0; i < 32; i++) begin
                regs[i]     <= '0;
                stat_tag[i] <= '0;
            end
        end else begin
            if (commit.valid && commit.write) begin
                regs[commit.rd] <= commit.value;
                // a newer writer keeps the register renamed
                if (stat_pend[commit.rd] && stat_tag[commit.rd] == commit.tag) begin
                    stat_pend[commit.rd] <= 1'b0;
                end
            end
            if (rs_issue && alloc.write) begin
                stat_pend[alloc.rd] <= 1'b1;
                stat_tag[alloc.rd]  <= alloc_tag;
            end
        end
    end

    // a stalled instruction stays presented, unchanged, until taken
    a_hold_under_stall: assert property (@(posedge clk) disable iff (!arst_n)
        in_valid && stall |=> in_valid && $stable(instr));

endmodule

//--- mul_unit.sv
// iterative shift-add multiplier, one bit per cycle, low word of the product
// result appears 33 cycles after the request and is held until granted
module mul_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  tomasulo_pkg::fu_req_t  req,
    input  logic                   grant,
    output tomasulo_pkg::cdb_t     result,
    output logic                   busy
);
    logic                           running;
    logic [5:0]                     step;
    logic [tomasulo_pkg::XLEN-1:0]  acc, mcand, mplier;
    logic [tomasulo_pkg::TAG_W-1:0] tag_q;

    assign busy = running | (result.valid & ~grant);

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
            step    <= '0;
            result  <= '0;
        end else begin
            if (grant) result.valid <= 1'b0;
            if (req.valid) begin
                running <= 1'b1;
                step    <= '0;
            end else if (running) begin
                if (step == 6'd32) begin
                    running <= 1'b0;
                    result  <= '{valid: 1'b1, tag: tag_q, value: acc};
                end else begin
                    step <= step + 6'd1;
                end
            end
        end
    end

    // --------------------------------------------------
    // datapath
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (req.valid) begin
            acc    <= '0;
            mcand  <= req.a;
            mplier <= req.b;
            tag_q  <= req.tag;
        end else if (running && step != 6'd32) begin
            if (mplier[0]) acc <= acc + mcand;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

endmodule

//--- reorder_buffer.sv
// circular reorder buffer: hands out tags at issue, collects bus results,
// answers operand lookups and retires the head in program order
module reorder_buffer (
    input  logic                             clk,
    input  logic                             arst_n,
    input  tomasulo_pkg::rob_alloc_t         alloc,
    input  logic                             alloc_valid,
    input  tomasulo_pkg::rob_query_t         query,
    input  tomasulo_pkg::cdb_t               cdb,
    output logic [tomasulo_pkg::TAG_W-1:0]   alloc_tag,
    output logic                             full,
    output tomasulo_pkg::rob_reply_t         reply,
    output tomasulo_pkg::commit_t            commit
);
    localparam int DEPTH = tomasulo_pkg::ROB_DEPTH;
    localparam int TW    = tomasulo_pkg::TAG_W;

    tomasulo_pkg::rob_alloc_t       dest  [DEPTH];
    logic [tomasulo_pkg::XLEN-1:0]  value [DEPTH];
    logic [DEPTH-1:0]               done;
    logic [TW-1:0]                  head, tail;
    logic [TW:0]                    count;

    assign alloc_tag = tail;
    assign full      = (count == (TW+1)'(DEPTH));

    assign reply.ready_j = done[query.tag_j];
    assign reply.ready_k = done[query.tag_k];
    assign reply.value_j = value[query.tag_j];
    assign reply.value_k = value[query.tag_k];

    // head retires as soon as its result is in
    assign commit.valid = (count != '0) && done[head];
    assign commit.rd    = dest[head].rd;
    assign commit.write = dest[head].write;
    assign commit.value = value[head];
    assign commit.tag   = head;

    // --------------------------------------------------
    // pointers and status
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            done  <= '0;
        end else begin
            if (cdb.valid) done[cdb.tag] <= 1'b1;
            if (alloc_valid) begin
                done[tail] <= 1'b0;
                tail       <= tail + 1'b1;
            end
            if (commit.valid) head <= head + 1'b1;
            count <= count + (TW+1)'(alloc_valid) - (TW+1)'(commit.valid);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid) dest[tail] <= alloc;
        if (cdb.valid) value[cdb.tag] <= cdb.value;
    end

    // a broadcast always targets a live entry that is still waiting
    a_cdb_live: assert property (@(posedge clk) disable iff (!arst_n)
        cdb.valid |-> !done[cdb.tag] && count != '0);

endmodule

//--- rs_bank.sv
// reservation stations for both unit classes; alu stations sit at the low
// indices, multiplier stations above them
module rs_bank #(
    parameter int N_ALU_RS = 3,
    parameter int N_MUL_RS = 2
) (
    input  logic                      clk,
    input  logic                      arst_n,
    input  tomasulo_pkg::rs_entry_t   rs_new,
    input  logic                      rs_issue,
    input  logic                      rs_is_mul,
    input  tomasulo_pkg::cdb_t        cdb,
    input  logic                      alu_busy,
    input  logic                      mul_busy,
    output logic                      alu_full,
    output logic                      mul_full,
    output tomasulo_pkg::fu_req_t     alu_req,
    output tomasulo_pkg::fu_req_t     mul_req
);
    localparam int N_RS = N_ALU_RS + N_MUL_RS;

    tomasulo_pkg::rs_entry_t entry [N_RS];
    logic [N_RS-1:0]         used;
    logic [N_RS-1:0]         ready;
    logic                    alu_has_free, mul_has_free, alu_has_ready, mul_has_ready;
    int                      alu_free, mul_free, alu_pick, mul_pick, new_idx;

    always_comb begin
        for (int i = 0; i < N_RS; i++) begin
            ready[i] = used[i] & ~entry[i].qj_pend & ~entry[i].qk_pend;
        end
    end

    // lowest free and lowest ready slot of each class
    always_comb begin
        alu_has_free  = 1'b0;
        alu_has_ready = 1'b0;
        alu_free      = 0;
        alu_pick      = 0;
        for (int i = N_ALU_RS - 1; i >= 0; i--) begin
            if (!used[i]) begin
                alu_has_free = 1'b1;
                alu_free     = i;
            end
            if (ready[i]) begin
                alu_has_ready = 1'b1;
                alu_pick      = i;
            end
        end
        mul_has_free  = 1'b0;
        mul_has_ready = 1'b0;
        mul_free      = N_ALU_RS;
        mul_pick      = N_ALU_RS;
        for (int i = N_RS - 1; i >= N_ALU_RS; i--) begin
            if (!used[i]) begin
                mul_has_free = 1'b1;
                mul_free     = i;
            end
            if (ready[i]) begin
                mul_has_ready = 1'b1;
                mul_pick      = i;
            end
        end
    end

    assign alu_full = ~alu_has_free;
    assign mul_full = ~mul_has_free;
    assign new_idx  = rs_is_mul ? mul_free : alu_free;

    assign alu_req = '{valid: alu_has_ready & ~alu_busy, op: entry[alu_pick].op,
                       tag: entry[alu_pick].tag, a: entry[alu_pick].vj, b: entry[alu_pick].vk};
    assign mul_req = '{valid: mul_has_ready & ~mul_busy, op: entry[mul_pick].op,
                       tag: entry[mul_pick].tag, a: entry[mul_pick].vj, b: entry[mul_pick].vk};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            used <= '0;
        end else begin
            if (alu_req.valid) used[alu_pick] <= 1'b0;
            if (mul_req.valid) used[mul_pick] <= 1'b0;
            if (rs_issue) used[new_idx] <= 1'b1;
        end
    end

    // operand capture from the bus, then the new entry
    always_ff @(posedge clk) begin
        for (int i = 0; i < N_RS; i++) begin
            if (cdb.valid && entry[i].qj_pend && entry[i].qj == cdb.tag) begin
                entry[i].vj      <= cdb.value;
                entry[i].qj_pend <= 1'b0;
            end
            if (cdb.valid && entry[i].qk_pend && entry[i].qk == cdb.tag) begin
                entry[i].vk      <= cdb.value;
                entry[i].qk_pend <= 1'b0;
            end
        end
        if (rs_issue) entry[new_idx] <= rs_new;
    end

    // the stall from issue must keep a full class from being written
    a_no_write_when_full: assert property (@(posedge clk) disable iff (!arst_n)
        rs_issue |-> !used[new_idx]);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    -f flist.f --top-module tb_tomasulo_core -Mdir obj_dir -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0

//--- tb_tomasulo_core.sv
// testbench for the out-of-order core: presents the words of commit_cases.txt
// under stall back-pressure with random idle gaps and checks the commit stream
module tb_tomasulo_core;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CASES   = 64;
    localparam int STALL_LIMIT = 300;
    localparam int DRAIN_LIMIT = 2000;

    logic                 clk;
    logic                 arst_n;
    logic                 in_valid;
    tomasulo_pkg::instr_u instr;
    logic                 stall;
    logic                 commit_valid;
    logic [4:0]           commit_rd;
    logic                 commit_write;
    logic [31:0]          commit_value;

    // word 0 is the count, then four words per instruction
    logic [31:0] case_mem [0:4*MAX_CASES];
    int          n_cases;
    int          n_commits;
    int          errors;
    int          checks;
    int          seed;
    logic        timed_out;
    logic        stall_seen;

    tomasulo_core u_tomasulo_core (
        .clk,
        .arst_n,
        .in_valid,
        .instr,
        .stall,
        .commit_valid,
        .commit_rd,
        .commit_write,
        .commit_value
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s: got %08h expected %08h", name, got, exp);
        end
    endtask

    // present one word and hold it until a cycle without stall takes it
    task automatic present(input int idx);
        int waited;
        waited   = 0;
        in_valid <= 1'b1;
        instr    <= case_mem[1 + 4*idx];
        @(negedge clk);
        while (stall && waited < STALL_LIMIT) begin
            stall_seen = 1'b1;
            waited++;
            @(negedge clk);
        end
        if (stall) begin
            errors++;
            timed_out = 1'b1;
            $display("timeout: instruction %0d was never taken, stall stayed high", idx);
        end
        @(posedge clk);
    endtask

    // --------------------------------------------------
    // commit checker
    // --------------------------------------------------
    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            if (n_commits >= n_cases) begin
                errors++;
                $display("a commit appeared after the last instruction had retired");
            end else begin
                check_value("commit_rd", 32'(commit_rd), case_mem[2 + 4*n_commits]);
                check_value("commit_write", 32'(commit_write), case_mem[3 + 4*n_commits]);
                // value only matters when a register is written
                if (case_mem[3 + 4*n_commits][0]) begin
                    check_value("commit_value", commit_value, case_mem[4 + 4*n_commits]);
                end
            end
            n_commits++;
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        int gap;
        int waited;
        arst_n     = 1'b0;
        in_valid   = 1'b0;
        instr      = '0;
        n_commits  = 0;
        errors     = 0;
        checks     = 0;
        seed       = 65135;
        timed_out  = 1'b0;
        stall_seen = 1'b0;
        $readmemh("commit_cases.txt", case_mem);
        n_cases = int'(case_mem[0]);
        if (n_cases <= 0 || n_cases > MAX_CASES) begin
            errors++;
            $display("the cases file holds an invalid instruction count %0d", n_cases);
            n_cases = 0;
        end

        repeat (3) @(posedge clk);
        arst_n <= 1'b1;

        // idle core after reset
        repeat (5) begin
            @(negedge clk);
            check_value("stall", 32'(stall), 32'd0);
            check_value("commit_valid", 32'(commit_valid), 32'd0);
        end
        @(posedge clk);

        for (int i = 0; i < n_cases && !timed_out; i++) begin
            present(i);
            gap = {$random(seed)} % 3;
            if (gap != 0) begin
                in_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
        end
        in_valid <= 1'b0;

        // drain the reorder buffer
        waited = 0;
        while (!timed_out && n_commits < n_cases && waited < DRAIN_LIMIT) begin
            waited++;
            @(negedge clk);
        end
        if (!timed_out && n_commits < n_cases) begin
            errors++;
            $display("timeout: only %0d of %0d instructions committed", n_commits, n_cases);
        end
        repeat (4) @(negedge clk);

        // the long multiplies back the input up at least once
        if (!stall_seen) begin
            errors++;
            $display("stall never rose while the instructions were presented");
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- tomasulo_core.sv
// top of the out-of-order core: issue, stations, units, bus and commit
// the instruction source presents one word at a time and holds it under stall
module tomasulo_core #(
    parameter int N_ALU_RS = 3,
    parameter int N_MUL_RS = 2
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            in_valid,
    input  tomasulo_pkg::instr_u            instr,
    output logic                            stall,
    output logic                            commit_valid,
    output logic [4:0]                      commit_rd,
    output logic                            commit_write,
    output logic [tomasulo_pkg::XLEN-1:0]   commit_value
);
    tomasulo_pkg::rob_alloc_t         alloc;
    tomasulo_pkg::rob_query_t         query;
    tomasulo_pkg::rob_reply_t         reply;
    tomasulo_pkg::rs_entry_t          rs_new;
    tomasulo_pkg::fu_req_t            alu_req, mul_req;
    tomasulo_pkg::cdb_t               alu_result, mul_result, cdb;
    tomasulo_pkg::commit_t            commit;
    logic [tomasulo_pkg::TAG_W-1:0]   alloc_tag;
    logic                             alloc_valid, rob_full;
    logic                             rs_issue, rs_is_mul, alu_full, mul_full;
    logic                             alu_busy, mul_busy, alu_grant, mul_grant;

    // --------------------------------------------------
    // issue and stations
    // --------------------------------------------------
    issue_stage #(.N_ALU_RS(N_ALU_RS), .N_MUL_RS(N_MUL_RS)) u_issue_stage (
        .clk, .arst_n, .in_valid, .instr, .alloc_tag, .rob_full, .reply,
        .alu_full, .mul_full, .cdb, .commit, .stall, .alloc, .alloc_valid,
        .query, .rs_new, .rs_issue, .rs_is_mul
    );

    rs_bank #(.N_ALU_RS(N_ALU_RS), .N_MUL_RS(N_MUL_RS)) u_rs_bank (
        .clk, .arst_n, .rs_new, .rs_issue, .rs_is_mul, .cdb, .alu_busy,
        .mul_busy, .alu_full, .mul_full, .alu_req, .mul_req
    );

    // --------------------------------------------------
    // execute, write-back and commit
    // --------------------------------------------------
    alu_unit u_alu_unit (
        .clk, .arst_n, .req(alu_req), .grant(alu_grant), .result(alu_result), .busy(alu_busy)
    );

    mul_unit u_mul_unit (
        .clk, .arst_n, .req(mul_req), .grant(mul_grant), .result(mul_result), .busy(mul_busy)
    );

    cdb_arbiter u_cdb_arbiter (.alu_result, .mul_result, .cdb, .alu_grant, .mul_grant);

    reorder_buffer u_reorder_buffer (
        .clk, .arst_n, .alloc, .alloc_valid, .query, .cdb, .alloc_tag,
        .full(rob_full), .reply, .commit
    );

    assign commit_valid = commit.valid;
    assign commit_rd    = commit.rd;
    assign commit_write = commit.write;
    assign commit_value = commit.value;

endmodule

//--- tomasulo_pkg.sv
// shared widths, instruction view and stage-to-stage records of the core
// every module refers to these by scoped name

package tomasulo_pkg;

    localparam int XLEN      = 32;
    localparam int TAG_W     = 3;
    localparam int ROB_DEPTH = 2 ** TAG_W;

    // --------------------------------------------------
    // instruction word
    // --------------------------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_view_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_view_t;

    typedef union packed {
        r_view_t r_view;
        i_view_t i_view;
    } instr_u;

    typedef enum logic [2:0] {
        OP_ADD,
        OP_SUB,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_MUL,
        OP_NOP
    } alu_op_e;

    // --------------------------------------------------
    // stage records
    // --------------------------------------------------
    typedef struct packed {
        alu_op_e             op;
        logic [TAG_W-1:0]    tag;
        logic [XLEN-1:0]     vj;
        logic [XLEN-1:0]     vk;
        logic [TAG_W-1:0]    qj;
        logic [TAG_W-1:0]    qk;
        logic                qj_pend;
        logic                qk_pend;
    } rs_entry_t;

    typedef struct packed {
        logic                valid;
        alu_op_e             op;
        logic [TAG_W-1:0]    tag;
        logic [XLEN-1:0]     a;
        logic [XLEN-1:0]     b;
    } fu_req_t;

    typedef struct packed {
        logic                valid;
        logic [TAG_W-1:0]    tag;
        logic [XLEN-1:0]     value;
    } cdb_t;

    typedef struct packed {
        logic [4:0] rd;
        logic       write;
    } rob_alloc_t;

    typedef struct packed {
        logic [TAG_W-1:0] tag_j;
        logic [TAG_W-1:0] tag_k;
    } rob_query_t;

    typedef struct packed {
        logic            ready_j;
        logic            ready_k;
        logic [XLEN-1:0] value_j;
        logic [XLEN-1:0] value_k;
    } rob_reply_t;

    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic             write;
        logic [XLEN-1:0]  value;
        logic [TAG_W-1:0] tag;
    } commit_t;

endpackage
